// File: src/dsp_pkg.sv
package dsp_pkg;

  // analog sample, signed two's complement
  typedef logic signed [13:0] sample_t;

  // raw ADC pin word, bits [1:0] reserved
  typedef logic [15:0] adc_raw_t;

  // calibration gain and offset
  typedef logic signed [15:0] cal_mul_t;
  typedef logic signed [13:0] cal_sum_t;

  // unity gain and matching post-multiply shift
  localparam int unsigned cal_unity = 16384;
  localparam int unsigned cal_shift = 14;

  // saturation limits of the sample range
  localparam sample_t sample_max = 14'sd8191;
  localparam sample_t sample_min = sample_t'(-8192);

  // DAC code, unsigned offset binary with inverted slope
  typedef logic [13:0] dac_code_t;

  // DAC bus interleaves exactly two channels
  localparam int unsigned num_dac_ch = 2;

  // sign bit kept, magnitude bits inverted
  function automatic dac_code_t dac_code(sample_t s);
    return {s[13], ~s[12:0]};
  endfunction

endpackage

// File: src/periph_pkg.sv
package periph_pkg;

  // PDM output level, 0 to 255 high cycles per 256
  typedef logic [7:0] pdm_lvl_t;

  // debounce settle counter
  typedef logic [19:0] db_cnt_t;

  // debounce FSM states
  typedef enum logic {
    // accepted level matches input
    DB_STABLE,
    // input differs, counting
    DB_SETTLE
  } db_state_e;

endpackage

// File: src/linear_calib.sv
`timescale 1ns/1ns

module linear_calib (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  dsp_pkg::sample_t  sample_i,
  input  dsp_pkg::cal_mul_t mul_i,
  input  dsp_pkg::cal_sum_t sum_i,
  output dsp_pkg::sample_t  sample_o
);

  // full product width 14 x 16
  logic signed [29:0] prod_d;
  logic signed [29:0] prod_q;
  // product scaled back by the unity gain
  logic signed [29:0] prod_sh;
  // offset sum with headroom for overflow
  logic signed [16:0] sum_d;
  dsp_pkg::sample_t   sat_d;

  // stage 1 multiply
  assign prod_d = sample_i * mul_i;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= prod_d;
    end
  end

  // stage 2 shift, offset, clamp
  assign prod_sh = prod_q >>> dsp_pkg::cal_shift;
  assign sum_d   = 17'(prod_sh) + 17'(sum_i);

  always_comb begin
    if (sum_d > dsp_pkg::sample_max) begin
      sat_d = dsp_pkg::sample_max;
    end else if (sum_d < dsp_pkg::sample_min) begin
      sat_d = dsp_pkg::sample_min;
    end else begin
      sat_d = sum_d[13:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sample_o <= '0;
    end else begin
      sample_o <= sat_d;
    end
  end

endmodule

// File: src/adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend #(
  parameter int unsigned num_adc_ch = 2
) (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  input  dsp_pkg::adc_raw_t [num_adc_ch-1:0]  adc_dat_i,
  input  dsp_pkg::sample_t  [num_adc_ch-1:0]  loop_dat_i,
  input  logic                                digital_loop_i,
  output dsp_pkg::sample_t  [num_adc_ch-1:0]  adc_dat_o
);

  for (genvar i = 0; i < num_adc_ch; i++) begin : g_ch

    // registered, format-converted ADC word
    dsp_pkg::sample_t raw_q;

    // input register right at the pins
    // drop two reserved bits, keep sign, flip the rest
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        raw_q <= '0;
      end else begin
        raw_q <= {adc_dat_i[i][15], ~adc_dat_i[i][14:2]};
      end
    end

    // digital loopback mux
    // loop sample comes straight from DAC calibration
    assign adc_dat_o[i] = digital_loop_i ? loop_dat_i[i] : raw_q;

  end

endmodule

// File: src/dac_backend.sv
`timescale 1ns/1ns

module dac_backend (
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  input  dsp_pkg::sample_t [dsp_pkg::num_dac_ch-1:0]  dac_dat_i,
  output dsp_pkg::dac_code_t                          dac_dat_o,
  output logic                                        dac_sel_o,
  output logic                                        dac_rst_o
);

  // per channel DAC codes
  dsp_pkg::dac_code_t [dsp_pkg::num_dac_ch-1:0] code;
  // first stage of DAC reset
  logic rst_q;

  for (genvar i = 0; i < dsp_pkg::num_dac_ch; i++) begin : g_code
    // inverted slope, offset binary
    assign code[i] = dsp_pkg::dac_code(dac_dat_i[i]);
  end

  // channel interleave
  // sel rising carries ch0, sel falling carries ch1
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= dsp_pkg::dac_code('0);
    end else begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= dac_sel_o ? code[1] : code[0];
    end
  end

  // DAC reset held one edge past top reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rst_q     <= 1'b1;
      dac_rst_o <= 1'b1;
    end else begin
      rst_q     <= 1'b0;
      dac_rst_o <= rst_q;
    end
  end

endmodule

// File: src/pdm_modulator.sv
`timescale 1ns/1ns

module pdm_modulator #(
  parameter int unsigned pdm_ch = 4
) (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  input  periph_pkg::pdm_lvl_t [pdm_ch-1:0] lvl_i,
  output logic                 [pdm_ch-1:0] pdm_o
);

  // level width
  localparam int unsigned lw = $bits(periph_pkg::pdm_lvl_t);

  for (genvar i = 0; i < pdm_ch; i++) begin : g_ch

    periph_pkg::pdm_lvl_t acc_q;
    // accumulator plus carry
    logic [lw:0] sum;
    logic        pdm_q;

    assign sum = {1'b0, acc_q} + {1'b0, lvl_i[i]};

    // first order sigma-delta, carry is the pulse
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end else begin
        acc_q <= sum[lw-1:0];
        pdm_q <= sum[lw];
      end
    end

    assign pdm_o[i] = pdm_q;

  end

endmodule

// File: src/edge_debounce.sv
`timescale 1ns/1ns

module edge_debounce #(
  parameter int unsigned debounce_len = 62500
) (
  input  logic adc_clk,
  input  logic top_rst,
  input  logic d_i,
  output logic pos_o,
  output logic neg_o
);

  // last count before a new level is accepted
  localparam periph_pkg::db_cnt_t cnt_last = periph_pkg::db_cnt_t'(debounce_len - 1);

  logic [1:0]            sync_q;
  logic                  lvl_q;
  logic                  diff;
  periph_pkg::db_state_e state_q;
  periph_pkg::db_cnt_t   cnt_q;

  // two flop synchronizer
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], d_i};
    end
  end

  // input disagrees with accepted level
  assign diff = sync_q[1] ^ lvl_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= periph_pkg::DB_STABLE;
      cnt_q   <= '0;
      lvl_q   <= 1'b0;
      pos_o   <= 1'b0;
      neg_o   <= 1'b0;
    end else begin
      // pulses last one cycle
      pos_o <= 1'b0;
      neg_o <= 1'b0;
      case (state_q)
        periph_pkg::DB_STABLE: begin
          // first differing cycle counts as one
          if (diff) begin
            state_q <= periph_pkg::DB_SETTLE;
            cnt_q   <= periph_pkg::db_cnt_t'(1);
          end
        end
        periph_pkg::DB_SETTLE: begin
          if (!diff) begin
            // glitch, drop it
            state_q <= periph_pkg::DB_STABLE;
          end else if (cnt_q == cnt_last) begin
            // level confirmed
            state_q <= periph_pkg::DB_STABLE;
            lvl_q   <= sync_q[1];
            pos_o   <= sync_q[1];
            neg_o   <= ~sync_q[1];
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= periph_pkg::DB_STABLE;
      endcase
    end
  end

endmodule

// File: src/rp_analog_top.sv
`timescale 1ns/1ns

module rp_analog_top #(
  parameter int unsigned num_adc_ch   = 2,
  parameter int unsigned pdm_ch       = 4,
  parameter int unsigned debounce_len = 62500
) (
  input  logic                                         adc_clk,
  input  logic                                         top_rst,
  // ADC pins and loopback
  input  dsp_pkg::adc_raw_t  [num_adc_ch-1:0]          adc_dat_i,
  input  logic                                         digital_loop_i,
  // calibration
  input  dsp_pkg::cal_mul_t  [num_adc_ch-1:0]          adc_cfg_mul_i,
  input  dsp_pkg::cal_sum_t  [num_adc_ch-1:0]          adc_cfg_sum_i,
  input  dsp_pkg::cal_mul_t  [dsp_pkg::num_dac_ch-1:0] dac_cfg_mul_i,
  input  dsp_pkg::cal_sum_t  [dsp_pkg::num_dac_ch-1:0] dac_cfg_sum_i,
  // generator samples
  input  dsp_pkg::sample_t   [dsp_pkg::num_dac_ch-1:0] gen_dat_i,
  // PDM levels and trigger pin
  input  periph_pkg::pdm_lvl_t [pdm_ch-1:0]            pdm_lvl_i,
  input  logic                                         exp_trg_i,
  // acquisition samples
  output dsp_pkg::sample_t   [num_adc_ch-1:0]          osc_dat_o,
  // DAC bus
  output dsp_pkg::dac_code_t                           dac_dat_o,
  output logic                                         dac_sel_o,
  output logic                                         dac_rst_o,
  // PDM and triggers
  output logic               [pdm_ch-1:0]              dac_pwm_o,
  output logic                                         trg_pos_o,
  output logic                                         trg_neg_o
);

  // calibrated generator samples, also the loopback source
  dsp_pkg::sample_t [dsp_pkg::num_dac_ch-1:0] dac_cal;
  // ADC or loopback stream before calibration
  dsp_pkg::sample_t [num_adc_ch-1:0]          adc_sel;

  ////////////////////////////////////////////////////////////////////////////
  // DAC path
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < dsp_pkg::num_dac_ch; i++) begin : g_dac
    linear_calib u_dac_calib (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .sample_i (gen_dat_i[i]),
      .mul_i    (dac_cfg_mul_i[i]),
      .sum_i    (dac_cfg_sum_i[i]),
      .sample_o (dac_cal[i])
    );
  end

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_dat_i (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ADC path
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend #(
    .num_adc_ch (num_adc_ch)
  ) u_adc (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat_i),
    .loop_dat_i     (dac_cal),
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_sel)
  );

  for (genvar i = 0; i < num_adc_ch; i++) begin : g_adc
    linear_calib u_adc_calib (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .sample_i (adc_sel[i]),
      .mul_i    (adc_cfg_mul_i[i]),
      .sum_i    (adc_cfg_sum_i[i]),
      .sample_o (osc_dat_o[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // PDM outputs and trigger
  ////////////////////////////////////////////////////////////////////////////

  pdm_modulator #(
    .pdm_ch (pdm_ch)
  ) u_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl_i),
    .pdm_o   (dac_pwm_o)
  );

  // expansion pin trigger edges
  edge_debounce #(
    .debounce_len (debounce_len)
  ) u_trg (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .d_i     (exp_trg_i),
    .pos_o   (trg_pos_o),
    .neg_o   (trg_neg_o)
  );

endmodule

// File: testbench/tb_rp_analog_top.sv
`timescale 1ns/1ns

module tb_rp_analog_top;

  // phase lengths in cycles
  localparam int reset_cycles  = 3;
  localparam int sample_cycles = 400;
  localparam int pdm_cycles    = 512;
  localparam int db_cycles     = 600;
  // run limit, all phases plus 20 percent
  localparam int timeout_cycles =
    (reset_cycles + sample_cycles + pdm_cycles + db_cycles) * 6 / 5;

  logic                       adc_clk;
  logic                       top_rst;
  dsp_pkg::adc_raw_t    [1:0] adc_dat;
  logic                       digital_loop;
  dsp_pkg::cal_mul_t    [1:0] adc_mul;
  dsp_pkg::cal_sum_t    [1:0] adc_sum;
  dsp_pkg::cal_mul_t    [1:0] dac_mul;
  dsp_pkg::cal_sum_t    [1:0] dac_sum;
  dsp_pkg::sample_t     [1:0] gen_dat;
  periph_pkg::pdm_lvl_t [3:0] pdm_lvl;
  logic                       exp_trg;
  dsp_pkg::sample_t     [1:0] osc_dat;
  dsp_pkg::dac_code_t         dac_dat;
  logic                       dac_sel;
  logic                       dac_rst;
  logic                 [3:0] dac_pwm;
  logic                       trg_pos;
  logic                       trg_neg;

  // stimulus history, indexed by drive cycle
  dsp_pkg::adc_raw_t [1:0] h_adc  [sample_cycles];
  dsp_pkg::cal_mul_t [1:0] h_amul [sample_cycles];
  dsp_pkg::cal_sum_t [1:0] h_asum [sample_cycles];
  dsp_pkg::cal_mul_t [1:0] h_dmul [sample_cycles];
  dsp_pkg::cal_sum_t [1:0] h_dsum [sample_cycles];
  dsp_pkg::sample_t  [1:0] h_gen  [sample_cycles];
  logic                    h_loop [sample_cycles];

  int seed;
  int err_cnt   = 0;
  int check_cnt = 0;
  int cyc_cnt   = 0;
  // trigger pulses seen in the current window
  int pos_cnt   = 0;
  int neg_cnt   = 0;

  rp_analog_top #(
    .num_adc_ch   (2),
    .pdm_ch       (4),
    .debounce_len (16)
  ) dut0 (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .digital_loop_i (digital_loop),
    .adc_cfg_mul_i  (adc_mul),
    .adc_cfg_sum_i  (adc_sum),
    .dac_cfg_mul_i  (dac_mul),
    .dac_cfg_sum_i  (dac_sum),
    .gen_dat_i      (gen_dat),
    .pdm_lvl_i      (pdm_lvl),
    .exp_trg_i      (exp_trg),
    .osc_dat_o      (osc_dat),
    .dac_dat_o      (dac_dat),
    .dac_sel_o      (dac_sel),
    .dac_rst_o      (dac_rst),
    .dac_pwm_o      (dac_pwm),
    .trg_pos_o      (trg_pos),
    .trg_neg_o      (trg_neg)
  );

  // 20 ns clock
  always #10 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic signed [63:0] act,
                           input logic signed [63:0] exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // gain, arithmetic shift by 14, offset, clamp to 14 bits
  function automatic dsp_pkg::sample_t calib_model(dsp_pkg::sample_t s,
                                                   dsp_pkg::cal_mul_t m,
                                                   dsp_pkg::cal_sum_t o);
    longint r;
    r = ((longint'(s) * longint'(m)) >>> 14) + longint'(o);
    if (r > 8191) begin
      r = 8191;
    end else if (r < -8192) begin
      r = -8192;
    end
    return dsp_pkg::sample_t'(r);
  endfunction

  // bits 15..2, low 13 of them flipped
  function automatic dsp_pkg::sample_t adc_fmt(dsp_pkg::adc_raw_t w);
    return dsp_pkg::sample_t'(w[15:2] ^ 14'h1fff);
  endfunction

  function automatic dsp_pkg::dac_code_t dac_code_model(dsp_pkg::sample_t s);
    return dsp_pkg::dac_code_t'(s) ^ 14'h1fff;
  endfunction

  // DAC calibration output right after edge k
  // product takes drive k-2, offset takes drive k-1
  function automatic dsp_pkg::sample_t dac_cal_at(int k, int c);
    return calib_model(h_gen[k-2][c], h_dmul[k-2][c], h_dsum[k-1][c]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // extremes mixed in to force saturation
  function automatic dsp_pkg::cal_mul_t rand_mul();
    case ($unsigned($random(seed)) % 6)
      0: return 16'sh7fff;
      1: return 16'sh8000;
      2: return 16'sd16384;
      default: return dsp_pkg::cal_mul_t'($random(seed));
    endcase
  endfunction

  function automatic dsp_pkg::cal_sum_t rand_sum();
    case ($unsigned($random(seed)) % 6)
      0: return 14'sd8191;
      1: return dsp_pkg::cal_sum_t'(-8192);
      2: return '0;
      default: return dsp_pkg::cal_sum_t'($random(seed));
    endcase
  endfunction

  function automatic dsp_pkg::sample_t rand_sample();
    case ($unsigned($random(seed)) % 6)
      0: return 14'sd8191;
      1: return dsp_pkg::sample_t'(-8192);
      default: return dsp_pkg::sample_t'($random(seed));
    endcase
  endfunction

  // second half of the sample phase runs in loopback
  task automatic drive_samples(input int n);
    for (int c = 0; c < 2; c++) begin
      adc_dat[c] = dsp_pkg::adc_raw_t'($random(seed));
      adc_mul[c] = rand_mul();
      adc_sum[c] = rand_sum();
      dac_mul[c] = rand_mul();
      dac_sum[c] = rand_sum();
      gen_dat[c] = rand_sample();
    end
    digital_loop = (n >= sample_cycles / 2);
    h_adc[n]  = adc_dat;
    h_amul[n] = adc_mul;
    h_asum[n] = adc_sum;
    h_dmul[n] = dac_mul;
    h_dsum[n] = dac_sum;
    h_gen[n]  = gen_dat;
    h_loop[n] = digital_loop;
  endtask

  // outputs settle 1 ns after the edge
  task automatic wait_sample();
    @(posedge adc_clk);
    #1;
    pos_cnt += trg_pos;
    neg_cnt += trg_neg;
  endtask

  // on to the drive point, 2 ns after the edge
  task automatic next_cycle();
    wait_sample();
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks per phase
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_samples(input int n);
    dsp_pkg::sample_t src;
    dsp_pkg::sample_t got;
    int               ch;
    check_val("dac_sel_o", dac_sel, n % 2);
    check_val("dac_rst_o", dac_rst, n == 1);
    if (n >= 4) begin
      for (int c = 0; c < 2; c++) begin
        // mux select and raw register both one stage ahead of calibration
        src = h_loop[n-2] ? dac_cal_at(n - 2, c) : adc_fmt(h_adc[n-3][c]);
        got = osc_dat[c];
        check_val($sformatf("osc_dat_o[%0d]", c), got,
                  calib_model(src, h_amul[n-2][c], h_asum[n-1][c]));
      end
      // select high after the edge means channel 0
      ch = (n % 2 == 1) ? 0 : 1;
      check_val("dac_dat_o", dac_dat, dac_code_model(dac_cal_at(n - 1, ch)));
    end
  endtask

  // 256 cycles at a constant level give exactly level high cycles
  task automatic run_pdm_window(input periph_pkg::pdm_lvl_t [3:0] lvl);
    int hi [4];
    pdm_lvl = lvl;
    for (int c = 0; c < 4; c++) begin
      hi[c] = 0;
    end
    repeat (256) begin
      wait_sample();
      for (int c = 0; c < 4; c++) begin
        hi[c] += dac_pwm[c];
      end
    end
    for (int c = 0; c < 4; c++) begin
      check_val($sformatf("dac_pwm_o[%0d] high cycles", c), hi[c], lvl[c]);
    end
    #1;
  endtask

  // short pulses away from lvl, none may get through
  task automatic glitch_burst(input logic lvl, input int count);
    int len;
    int gap;
    pos_cnt = 0;
    neg_cnt = 0;
    repeat (count) begin
      len = 1 + $unsigned($random(seed)) % 15;
      gap = 1 + $unsigned($random(seed)) % 4;
      exp_trg = ~lvl;
      repeat (len) next_cycle();
      exp_trg = lvl;
      repeat (gap) next_cycle();
    end
    repeat (16) next_cycle();
    check_val("trg_pos_o glitch pulses", pos_cnt, 0);
    check_val("trg_neg_o glitch pulses", neg_cnt, 0);
  endtask

  task automatic hold_level(input logic lvl);
    int lat;
    pos_cnt = 0;
    neg_cnt = 0;
    lat     = 0;
    exp_trg = lvl;
    for (int i = 1; i <= 40; i++) begin
      wait_sample();
      if ((trg_pos || trg_neg) && lat == 0) begin
        lat = i;
      end
      #1;
    end
    check_val("trg_pos_o pulses", pos_cnt, lvl);
    check_val("trg_neg_o pulses", neg_cnt, !lvl);
    if (lat > 20) begin
      err_cnt++;
      $display("Error: trigger pulse came %0d cycles after the input change, limit 20", lat);
    end
  endtask

  initial begin
    seed         = 49;
    adc_clk      = 1'b0;
    top_rst      = 1'b1;
    adc_dat      = '0;
    digital_loop = 1'b0;
    adc_mul      = '0;
    adc_sum      = '0;
    dac_mul      = '0;
    dac_sum      = '0;
    gen_dat      = '0;
    pdm_lvl      = '0;
    exp_trg      = 1'b0;
    repeat (reset_cycles) @(posedge adc_clk);
    #2;
    top_rst = 1'b0;
    // sample paths, ADC then loopback
    drive_samples(0);
    for (int n = 1; n < sample_cycles; n++) begin
      wait_sample();
      check_samples(n);
      #1;
      drive_samples(n);
    end
    // PDM, first window pins both ends of the range
    run_pdm_window({8'd255, 8'd0, 8'($random(seed)), 8'($random(seed))});
    run_pdm_window({8'($random(seed)), 8'($random(seed)),
                    8'($random(seed)), 8'($random(seed))});
    // trigger debounce
    glitch_burst(1'b0, 6);
    for (int k = 0; k < 6; k++) begin
      hold_level(k % 2 == 0);
      glitch_burst(k % 2 == 0, 1);
    end
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb.f
src/dsp_pkg.sv
src/periph_pkg.sv
src/linear_calib.sv
src/adc_frontend.sv
src/dac_backend.sv
src/pdm_modulator.sv
src/edge_debounce.sv
src/rp_analog_top.sv
testbench/tb_rp_analog_top.sv

// File: Bender.yml
package:
  name: rp_analog_top

sources:
  # packages
  - src/dsp_pkg.sv
  - src/periph_pkg.sv
  # signal chain
  - src/linear_calib.sv
  - src/adc_frontend.sv
  - src/dac_backend.sv
  - src/pdm_modulator.sv
  - src/edge_debounce.sv
  - src/rp_analog_top.sv
  # testbench
  - target: simulation
    files:
      - testbench/tb_rp_analog_top.sv
